// File: design/acog_alu_top.sv
/*
 * ACog ALU top level
 * Operand register, three parallel units and result register
 */
`timescale 1ns/1ps

module acog_alu_top
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
(
	input  logic    clk_in,
	input  logic    rst_i,
	input  logic    valid_i,
	input  alu_op_e op_i,
	input  word_t   s_i,
	input  word_t   d_i,
	input  logic    flag_c_i,
	input  logic    flag_z_i,
	output logic    valid_o,
	output word_t   q_o,
	output logic    flag_c_o,
	output logic    flag_z_o
);

	logic    valid_r;
	alu_op_e op_r;
	word_t   s_r, d_r, s_neg_r, s_abs_r, s_inv_r;
	logic    c_r, z_r;
	word_t   arith_q, logic_q, shift_q;
	logic    arith_c, logic_c, shift_c;
	logic    cmp_lt;

	acog_operand_stage u_operand (
		.clk_in(clk_in), .rst_i(rst_i), .valid_i(valid_i), .op_i(op_i),
		.s_i(s_i), .d_i(d_i), .flag_c_i(flag_c_i), .flag_z_i(flag_z_i),
		.valid_o(valid_r), .op_o(op_r), .s_o(s_r), .d_o(d_r),
		.s_neg_o(s_neg_r), .s_abs_o(s_abs_r), .s_inv_o(s_inv_r), .c_o(c_r), .z_o(z_r)
	);

	acog_arith u_arith (
		.op_i(op_r), .s_i(s_r), .d_i(d_r), .s_neg_i(s_neg_r), .s_abs_i(s_abs_r),
		.c_i(c_r), .z_i(z_r), .q_o(arith_q), .c_o(arith_c), .cmp_lt_o(cmp_lt)
	);

	acog_logic u_logic (
		.op_i(op_r), .s_i(s_r), .d_i(d_r), .s_inv_i(s_inv_r),
		.c_i(c_r), .z_i(z_r), .q_o(logic_q), .c_o(logic_c)
	);

	acog_shifter u_shifter (
		.op_i(op_r), .s_i(s_r), .d_i(d_r), .c_i(c_r), .q_o(shift_q), .c_o(shift_c)
	);

	// Second pipeline register
	acog_result_stage u_result (
		.clk_in(clk_in), .rst_i(rst_i), .valid_i(valid_r), .op_i(op_r),
		.s_i(s_r), .d_i(d_r), .s_neg_i(s_neg_r), .s_abs_i(s_abs_r), .c_i(c_r), .z_i(z_r),
		.arith_q_i(arith_q), .arith_c_i(arith_c), .cmp_lt_i(cmp_lt),
		.logic_q_i(logic_q), .logic_c_i(logic_c), .shift_q_i(shift_q), .shift_c_i(shift_c),
		.valid_o(valid_o), .q_o(q_o), .flag_c_o(flag_c_o), .flag_z_o(flag_z_o)
	);

endmodule

// File: design/acog_arith.sv
/*
 * ACog ALU arithmetic unit
 * Add and subtract with optional carry-in, absolute-value forms,
 * signed compare and the flag-selected conditional sums
 */
`timescale 1ns/1ps

module acog_arith
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
(
	input  alu_op_e op_i,
	input  word_t   s_i,
	input  word_t   d_i,
	input  word_t   s_neg_i,
	input  word_t   s_abs_i,
	input  logic    c_i,
	input  logic    z_i,
	output word_t   q_o,
	output logic    c_o,
	output logic    cmp_lt_o
);

	logic              x;        // Extend bit, C for the X forms
	logic [WORD_W:0]   add_x;
	logic [WORD_W:0]   sub_x;
	logic [WORD_W:0]   add_abs;
	logic [WORD_W:0]   sub_abs;
	logic [WORD_W:0]   cmp;
	logic [WORD_W:0]   cmp_x;
	word_t             bias_d;
	word_t             bias_s;
	word_t             sum_b;
	word_t             sum_q;
	logic              sum_neg;

	// Signed overflow of a + b from the sign bits
	function automatic logic add_ovf(input logic a, input logic b, input logic r);
		return (a == b) && (r != a);
	endfunction

	assign x = (op_i inside {OP_ADDSX, OP_ADDX, OP_SUBSX, OP_SUBX, OP_CMPSX}) & c_i;

	assign add_x   = {1'b0, d_i} + {1'b0, s_i} + {{WORD_W{1'b0}}, x};
	assign sub_x   = {1'b0, d_i} - {1'b0, s_i} - {{WORD_W{1'b0}}, x};
	assign add_abs = {1'b0, d_i} + {1'b0, s_abs_i};
	assign sub_abs = {1'b0, d_i} - {1'b0, s_abs_i};

	// Flipped sign bits turn the unsigned borrow into a signed compare
	assign bias_d   = {~d_i[WORD_W-1], d_i[WORD_W-2:0]};
	assign bias_s   = {~s_i[WORD_W-1], s_i[WORD_W-2:0]};
	assign cmp      = {1'b0, bias_d} - {1'b0, bias_s};
	assign cmp_x    = cmp - {{WORD_W{1'b0}}, x};
	assign cmp_lt_o = cmp[WORD_W]; // Signed D < S

	always_comb
	begin
		case (op_i)
			OP_SUMC:  sum_neg = c_i;
			OP_SUMNC: sum_neg = !c_i;
			OP_SUMZ:  sum_neg = z_i;
			default:  sum_neg = !z_i;
		endcase
	end

	assign sum_b = sum_neg ? s_neg_i : s_i;
	assign sum_q = d_i + sum_b;

	always_comb
	begin
		q_o = add_x[WORD_W-1:0]; // ADD, ADDX
		c_o = add_x[WORD_W];
		case (op_i)
			OP_ADDABS:
			begin
				q_o = add_abs[WORD_W-1:0];
				c_o = add_abs[WORD_W];
			end
			OP_ADDS, OP_ADDSX: c_o = add_ovf(d_i[WORD_W-1], s_i[WORD_W-1], add_x[WORD_W-1]);
			OP_SUB, OP_SUBX:
			begin
				q_o = sub_x[WORD_W-1:0];
				c_o = sub_x[WORD_W];
			end
			OP_SUBABS:
			begin
				q_o = sub_abs[WORD_W-1:0];
				c_o = sub_abs[WORD_W];
			end
			OP_SUBS, OP_SUBSX:
			begin
				q_o = sub_x[WORD_W-1:0];
				c_o = add_ovf(d_i[WORD_W-1], ~s_i[WORD_W-1], sub_x[WORD_W-1]);
			end
			OP_CMPSUB:
			begin
				q_o = sub_x[WORD_W] ? d_i : sub_x[WORD_W-1:0]; // Keep D when S is larger
				c_o = !sub_x[WORD_W];
			end
			OP_CMPS, OP_CMPSX:
			begin
				q_o = cmp_x[WORD_W-1:0];
				c_o = cmp_x[WORD_W];
			end
			OP_SUMC, OP_SUMNC, OP_SUMZ, OP_SUMNZ:
			begin
				q_o = sum_q;
				c_o = add_ovf(d_i[WORD_W-1], sum_b[WORD_W-1], sum_q[WORD_W-1]);
			end
			default: ;
		endcase
	end

endmodule

// File: design/acog_cfg_pkg.sv
/*
 * ACog ALU data-path configuration
 * Word and shift-amount widths with their vector types
 */
package acog_cfg_pkg;

	// Data word
	localparam int WORD_W = 32;

	// Shift amount, taken from the low bits of S
	localparam int SHAMT_W = 5;

	typedef logic [WORD_W-1:0] word_t;   // S, D and result
	typedef logic [SHAMT_W-1:0] shamt_t;

endpackage

// File: design/acog_isa_pkg.sv
/*
 * ACog ALU instruction set
 * Opcode encoding and opcode group field values.
 * The top three opcode bits select the group
 */
package acog_isa_pkg;

	localparam int OP_W = 6;
	localparam int GRP_W = 3;

	// Group field values, opcode bits 5:3
	localparam logic [GRP_W-1:0] GRP_ADD   = 3'd0; // Add, compare
	localparam logic [GRP_W-1:0] GRP_SUB   = 3'd1;
	localparam logic [GRP_W-1:0] GRP_SUM   = 3'd2; // Conditional sums
	localparam logic [GRP_W-1:0] GRP_LOGIC = 3'd3;
	localparam logic [GRP_W-1:0] GRP_SHIFT = 3'd4;
	localparam logic [GRP_W-1:0] GRP_MOV   = 3'd5; // MOV, NEG and ABS forms
	localparam logic [GRP_W-1:0] GRP_MIN   = 3'd6; // MIN and MAX forms

	typedef enum logic [OP_W-1:0] {
		OP_ADD    = 6'h00, OP_ADDABS = 6'h01, OP_ADDS   = 6'h02, OP_ADDSX = 6'h03,
		OP_ADDX   = 6'h04, OP_CMPSUB = 6'h05, OP_CMPS   = 6'h06, OP_CMPSX = 6'h07,
		OP_SUB    = 6'h08, OP_SUBABS = 6'h09, OP_SUBS   = 6'h0a, OP_SUBSX = 6'h0b,
		OP_SUBX   = 6'h0c,
		OP_SUMC   = 6'h10, OP_SUMNC  = 6'h11, OP_SUMZ   = 6'h12, OP_SUMNZ = 6'h13,
		OP_AND    = 6'h18, OP_ANDN   = 6'h19, OP_OR     = 6'h1a, OP_XOR   = 6'h1b,
		OP_MUXC   = 6'h1c, OP_MUXNC  = 6'h1d, OP_MUXZ   = 6'h1e, OP_MUXNZ = 6'h1f,
		OP_SHL    = 6'h20, OP_SHR    = 6'h21, OP_SAR    = 6'h22, OP_ROL   = 6'h23,
		OP_ROR    = 6'h24, OP_RCL    = 6'h25, OP_RCR    = 6'h26, OP_REV   = 6'h27,
		OP_MOV    = 6'h28, OP_NEG    = 6'h29, OP_NEGC   = 6'h2a, OP_NEGNC = 6'h2b,
		OP_NEGZ   = 6'h2c, OP_NEGNZ  = 6'h2d, OP_ABS    = 6'h2e, OP_ABSNEG = 6'h2f,
		OP_MIN    = 6'h30, OP_MAX    = 6'h31, OP_MINS   = 6'h32, OP_MAXS  = 6'h33
	} alu_op_e;

endpackage

// File: design/acog_logic.sv
/*
 * ACog ALU logic unit
 * Bitwise ops and flag-controlled masked fill, C is result parity
 */
`timescale 1ns/1ps

module acog_logic
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
(
	input  alu_op_e op_i,
	input  word_t   s_i,
	input  word_t   d_i,
	input  word_t   s_inv_i,
	input  logic    c_i,
	input  logic    z_i,
	output word_t   q_o,
	output logic    c_o
);

	word_t fold;
	logic  fill;

	// Condition for the MUX forms
	always_comb
	begin
		case (op_i)
			OP_MUXC:  fill = c_i;
			OP_MUXNC: fill = !c_i;
			OP_MUXZ:  fill = z_i;
			default:  fill = !z_i;
		endcase
	end

	always_comb
	begin
		case (op_i)
			OP_AND:  q_o = d_i & s_i;
			OP_ANDN: q_o = d_i & s_inv_i;
			OP_OR:   q_o = d_i | s_i;
			OP_XOR:  q_o = d_i ^ s_i;
			default: q_o = (d_i & s_inv_i) | (fill ? s_i : '0); // D outside mask
		endcase
	end

	// XOR fold, halving the width on each pass
	always_comb
	begin
		fold = q_o;
		for (int w = WORD_W / 2; w > 0; w = w / 2)
		begin
			for (int i = 0; i < w; i++)
				fold[i] = fold[i] ^ fold[i + w];
		end
	end

	assign c_o = fold[0]; // Odd parity

endmodule

// File: design/acog_operand_stage.sv
/*
 * ACog ALU operand stage
 * Captures opcode, S, D and flags on a valid strobe and
 * precomputes -S, |S| and ~S for the processing units
 */
`timescale 1ns/1ps

module acog_operand_stage
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
(
	input  logic    clk_in,
	input  logic    rst_i,
	input  logic    valid_i,
	input  alu_op_e op_i,
	input  word_t   s_i,
	input  word_t   d_i,
	input  logic    flag_c_i,
	input  logic    flag_z_i,
	output logic    valid_o,
	output alu_op_e op_o,
	output word_t   s_o,
	output word_t   d_o,
	output word_t   s_neg_o,
	output word_t   s_abs_o,
	output word_t   s_inv_o,
	output logic    c_o,
	output logic    z_o
);

	word_t s_neg;

	assign s_neg = -s_i; // Two's complement

	always_ff @(posedge clk_in)
	begin
		if (rst_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// Operands only move when a new operation arrives
	always_ff @(posedge clk_in)
	begin
		if (valid_i)
		begin
			op_o    <= op_i;
			s_o     <= s_i;
			d_o     <= d_i;
			s_neg_o <= s_neg;
			s_abs_o <= s_i[WORD_W-1] ? s_neg : s_i;
			s_inv_o <= ~s_i;
			c_o     <= flag_c_i;
			z_o     <= flag_z_i;
		end
	end

endmodule

// File: design/acog_result_stage.sv
/*
 * ACog ALU result stage
 * Picks the unit output by opcode group, handles the
 * MOV/NEG/ABS/MIN/MAX forms directly and registers Q, C and Z
 */
`timescale 1ns/1ps

module acog_result_stage
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
(
	input  logic    clk_in,
	input  logic    rst_i,
	input  logic    valid_i,
	input  alu_op_e op_i,
	input  word_t   s_i,
	input  word_t   d_i,
	input  word_t   s_neg_i,
	input  word_t   s_abs_i,
	input  logic    c_i,
	input  logic    z_i,
	input  word_t   arith_q_i,
	input  logic    arith_c_i,
	input  logic    cmp_lt_i,
	input  word_t   logic_q_i,
	input  logic    logic_c_i,
	input  word_t   shift_q_i,
	input  logic    shift_c_i,
	output logic    valid_o,
	output word_t   q_o,
	output logic    flag_c_o,
	output logic    flag_z_o
);

	logic [GRP_W-1:0] grp;
	word_t            q_sel;
	logic             c_sel;
	logic             z_sel;

	assign grp = op_i[OP_W-1 -: GRP_W];

	always_comb
	begin
		q_sel = s_i;            // MOV
		c_sel = s_i[WORD_W-1];
		case (grp)
			GRP_ADD, GRP_SUB, GRP_SUM:
			begin
				q_sel = arith_q_i;
				c_sel = arith_c_i;
			end
			GRP_LOGIC:
			begin
				q_sel = logic_q_i;
				c_sel = logic_c_i;
			end
			GRP_SHIFT:
			begin
				q_sel = shift_q_i;
				c_sel = shift_c_i;
			end
			GRP_MOV:
				case (op_i)
					OP_NEG:    q_sel = s_neg_i;
					OP_NEGC:   q_sel = c_i ? s_neg_i : s_i;
					OP_NEGNC:  q_sel = c_i ? s_i : s_neg_i;
					OP_NEGZ:   q_sel = z_i ? s_neg_i : s_i;
					OP_NEGNZ:  q_sel = z_i ? s_i : s_neg_i;
					OP_ABS:    q_sel = s_abs_i;
					OP_ABSNEG: q_sel = s_i[WORD_W-1] ? s_i : s_neg_i; // -|S|
					default:   q_sel = s_i;
				endcase
			GRP_MIN:
			begin
				case (op_i)
					OP_MIN:  q_sel = (d_i > s_i) ? d_i : s_i;
					OP_MAX:  q_sel = (d_i < s_i) ? d_i : s_i;
					OP_MINS: q_sel = cmp_lt_i ? s_i : d_i;
					default: q_sel = cmp_lt_i ? d_i : s_i; // MAXS
				endcase
				c_sel = (op_i inside {OP_MINS, OP_MAXS}) ? cmp_lt_i : (d_i < s_i);
			end
			default: ;
		endcase
	end

	always_comb
	begin
		z_sel = (q_sel == '0);
		if (op_i inside {OP_ADDSX, OP_ADDX, OP_SUBSX, OP_SUBX, OP_CMPSX})
			z_sel = z_sel & z_i; // Chained over multi-word ops
		if (grp == GRP_MIN)
			z_sel = (s_i == '0);
	end

	always_ff @(posedge clk_in)
	begin
		if (rst_i)
		begin
			valid_o  <= 1'b0;
			q_o      <= '0;
			flag_c_o <= 1'b0;
			flag_z_o <= 1'b0;
		end
		else
		begin
			valid_o <= valid_i;
			if (valid_i)
			begin
				q_o      <= q_sel;
				flag_c_o <= c_sel;
				flag_z_o <= z_sel;
			end
		end
	end

endmodule

// File: design/acog_shifter.sv
/*
 * ACog ALU shifter
 * Shifts, rotates, rotate through carry and bit reverse of D
 * by the low five bits of S, built from per-bit index loops
 */
`timescale 1ns/1ps

module acog_shifter
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
(
	input  alu_op_e op_i,
	input  word_t   s_i,
	input  word_t   d_i,
	input  logic    c_i,
	output word_t   q_o,
	output logic    c_o
);

	shamt_t amt;
	word_t  rev_d;

	assign amt = s_i[SHAMT_W-1:0];

	always_comb
	begin
		for (int i = 0; i < WORD_W; i++)
			rev_d[i] = d_i[WORD_W-1-i];
	end

	// Each result bit picks its source bit, lj for left ops, rj for right ops
	always_comb
	begin
		int lj;
		int rj;
		q_o = d_i;
		for (int i = 0; i < WORD_W; i++)
		begin
			lj = i - int'(amt);
			rj = i + int'(amt);
			case (op_i)
				OP_SHL: q_o[i] = (lj >= 0) ? d_i[lj] : 1'b0;
				OP_ROL: q_o[i] = (lj >= 0) ? d_i[lj] : d_i[lj + WORD_W];
				OP_RCL: q_o[i] = (lj >= 0) ? d_i[lj] : c_i;
				OP_SHR: q_o[i] = (rj < WORD_W) ? d_i[rj] : 1'b0;
				OP_SAR: q_o[i] = (rj < WORD_W) ? d_i[rj] : d_i[WORD_W-1]; // Sign fill
				OP_ROR: q_o[i] = (rj < WORD_W) ? d_i[rj] : d_i[rj - WORD_W];
				OP_RCR: q_o[i] = (rj < WORD_W) ? d_i[rj] : c_i;
				OP_REV: q_o[i] = (rj < WORD_W) ? rev_d[rj] : 1'b0;
				default: q_o[i] = d_i[i];
			endcase
		end
	end

	// Bit leaving first, independent of the amount
	assign c_o = (op_i inside {OP_SHL, OP_ROL, OP_RCL}) ? d_i[WORD_W-1] : d_i[0];

endmodule

// File: include/acog_ref_model.svh
/*
 * ACog ALU reference model
 * Expected Q, C and Z for one operation, computed with
 * plain operators and wide signed arithmetic
 */
`ifndef ACOG_REF_MODEL_SVH
`define ACOG_REF_MODEL_SVH

// True when r does not fit a signed word
function automatic logic acog_ref_ovf(input longint r);
	return r != longint'($signed(r[WORD_W-1:0]));
endfunction

function automatic void acog_ref_model(
	input  alu_op_e op,
	input  word_t   s,
	input  word_t   d,
	input  logic    c_in,
	input  logic    z_in,
	output word_t   q,
	output logic    c_out,
	output logic    z_out
);
	longint          ls;
	longint          ld;
	longint          ln;
	longint          lx;
	logic [WORD_W:0] u_add;
	logic [WORD_W:0] u_sub;
	word_t           sn;
	word_t           sa;
	word_t           ones;
	word_t           dr;
	logic            x;
	logic            lt;
	logic            neg;
	int              amt;
	sn    = -s;
	sa    = s[WORD_W-1] ? sn : s;
	ones  = '1;
	dr    = {<<{d}};
	amt   = s[SHAMT_W-1:0];
	ls    = $signed(s);
	ld    = $signed(d);
	ln    = $signed(sn);
	lt    = ld < ls;
	x     = (op inside {OP_ADDSX, OP_ADDX, OP_SUBSX, OP_SUBX, OP_CMPSX}) ? c_in : 1'b0;
	lx    = x; // Signed copy keeps the wide sums signed
	neg   = (op == OP_SUMC) ? c_in : (op == OP_SUMNC) ? !c_in : (op == OP_SUMZ) ? z_in : !z_in;
	u_add = {1'b0, d} + {1'b0, s} + x;
	u_sub = {1'b0, d} - {1'b0, s} - x;
	q     = s;
	c_out = s[WORD_W-1];
	case (op)
		OP_ADD, OP_ADDX:   {c_out, q} = u_add;
		OP_ADDS, OP_ADDSX: {c_out, q} = {acog_ref_ovf(ld + ls + lx), u_add[WORD_W-1:0]};
		OP_ADDABS:         {c_out, q} = {1'b0, d} + {1'b0, sa};
		OP_SUB, OP_SUBX:   {c_out, q} = u_sub;
		OP_SUBS, OP_SUBSX: {c_out, q} = {acog_ref_ovf(ld - ls - lx), u_sub[WORD_W-1:0]};
		OP_SUBABS:         {c_out, q} = {1'b0, d} - {1'b0, sa};
		OP_CMPSUB:         {c_out, q} = (d >= s) ? {1'b1, d - s} : {1'b0, d};
		OP_CMPS, OP_CMPSX: {c_out, q} = {(ld - ls - lx) < 0, u_sub[WORD_W-1:0]};
		OP_SUMC, OP_SUMNC, OP_SUMZ, OP_SUMNZ:
			{c_out, q} = {acog_ref_ovf(ld + (neg ? ln : ls)), d + (neg ? sn : s)};
		OP_AND:    q = d & s;
		OP_ANDN:   q = d & ~s;
		OP_OR:     q = d | s;
		OP_XOR:    q = d ^ s;
		OP_MUXC:   q = (d & ~s) | (c_in ? s : '0);
		OP_MUXNC:  q = (d & ~s) | (c_in ? '0 : s);
		OP_MUXZ:   q = (d & ~s) | (z_in ? s : '0);
		OP_MUXNZ:  q = (d & ~s) | (z_in ? '0 : s);
		OP_SHL:    {c_out, q} = {d[WORD_W-1], d << amt};
		OP_SHR:    {c_out, q} = {d[0], d >> amt};
		OP_SAR:    {c_out, q} = {d[0], word_t'($signed(d) >>> amt)};
		OP_ROL:    {c_out, q} = {d[WORD_W-1], (d << amt) | (d >> (WORD_W - amt))};
		OP_ROR:    {c_out, q} = {d[0], (d >> amt) | (d << (WORD_W - amt))};
		OP_RCL:    {c_out, q} = {d[WORD_W-1], (d << amt) | (c_in ? ~(ones << amt) : '0)};
		OP_RCR:    {c_out, q} = {d[0], (d >> amt) | (c_in ? ~(ones >> amt) : '0)};
		OP_REV:    {c_out, q} = {d[0], dr >> amt};
		OP_NEG:    q = sn;
		OP_NEGC:   q = c_in ? sn : s;
		OP_NEGNC:  q = c_in ? s : sn;
		OP_NEGZ:   q = z_in ? sn : s;
		OP_NEGNZ:  q = z_in ? s : sn;
		OP_ABS:    q = sa;
		OP_ABSNEG: q = -sa;
		OP_MIN:    {c_out, q} = {d < s, (d < s) ? s : d};
		OP_MAX:    {c_out, q} = {d < s, (d > s) ? s : d};
		OP_MINS:   {c_out, q} = {lt, lt ? s : d};
		OP_MAXS:   {c_out, q} = {lt, lt ? d : s};
		default:   q = s;
	endcase
	if (op[OP_W-1 -: GRP_W] == GRP_LOGIC)
		c_out = ^q;
	z_out = (q == '0);
	if (op inside {OP_ADDSX, OP_ADDX, OP_SUBSX, OP_SUBX, OP_CMPSX})
		z_out = z_out & z_in;
	if (op[OP_W-1 -: GRP_W] == GRP_MIN)
		z_out = (s == '0);
endfunction

`endif

// File: dv/acog_alu_tb.sv
/*
 * ACog ALU testbench
 * Corner and random operations applied back to back,
 * results checked in issue order against expected values
 */
`timescale 1ns/1ps

module acog_alu_tb
	import acog_cfg_pkg::*;
	import acog_isa_pkg::*;
();

	localparam int RESET_CYC   = 16;
	localparam int RAND_PER_OP = 4;
	localparam int LATENCY     = 2;

	typedef struct packed {
		alu_op_e op;
		word_t   s;
		word_t   d;
		logic    c;
		logic    z;
		word_t   eq;
		logic    ec;
		logic    ez;
	} row_t;

	`include "acog_ref_model.svh"

	logic    clk_in;
	logic    rst_i;
	logic    valid_i;
	alu_op_e op_i;
	word_t   s_i;
	word_t   d_i;
	logic    flag_c_i;
	logic    flag_z_i;
	logic    valid_o;
	word_t   q_o;
	logic    flag_c_o;
	logic    flag_z_o;

	row_t        tbl[$];
	row_t        pending[$]; // Oldest row in flight first
	int          issued[$];
	int          cycles = 0;
	int          limit;
	int          err_val = 0;
	int          err_hs = 0;
	logic [31:0] lfsr = 32'd5;

	acog_alu_top UUT (
		.clk_in(clk_in), .rst_i(rst_i), .valid_i(valid_i), .op_i(op_i),
		.s_i(s_i), .d_i(d_i), .flag_c_i(flag_c_i), .flag_z_i(flag_z_i),
		.valid_o(valid_o), .q_o(q_o), .flag_c_o(flag_c_o), .flag_z_o(flag_z_o)
	);

	always #20 clk_in = ~clk_in;

	always @(posedge clk_in)
		cycles <= cycles + 1;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			b    = lfsr[0];
			lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h80200003 : 32'h0); // x^32+x^22+x^2+x+1
			r    = {r[30:0], b};
		end
		return r;
	endfunction

	task automatic add_row(input alu_op_e op, input word_t s, input word_t d, input logic c,
		input logic z, input word_t eq, input logic ec, input logic ez);
		row_t r;
		r = {op, s, d, c, z, eq, ec, ez};
		tbl.push_back(r);
	endtask

	task automatic add_fixed_rows();
		// op, S, D, C, Z, then expected Q, C, Z
		add_row(OP_ADD,    32'h00000001, 32'hffffffff, 0, 0, 32'h00000000, 1, 1);
		add_row(OP_ADDX,   32'h00000000, 32'hffffffff, 1, 1, 32'h00000000, 1, 1);
		add_row(OP_ADDS,   32'h00000001, 32'h7fffffff, 0, 0, 32'h80000000, 1, 0);
		add_row(OP_SUBS,   32'h00000001, 32'h80000000, 0, 0, 32'h7fffffff, 1, 0);
		add_row(OP_SUBX,   32'h00000005, 32'h00000005, 1, 1, 32'hffffffff, 1, 0);
		add_row(OP_CMPSUB, 32'h00000005, 32'h00000007, 0, 0, 32'h00000002, 1, 0);
		add_row(OP_CMPS,   32'h00000001, 32'hffffffff, 0, 0, 32'hfffffffe, 1, 0);
		add_row(OP_CMPSX,  32'h00000001, 32'h00000001, 0, 1, 32'h00000000, 0, 1);
		add_row(OP_ADDABS, 32'hffffffff, 32'hffffffff, 0, 0, 32'h00000000, 1, 1);
		add_row(OP_SUMC,   32'h00000001, 32'h80000000, 1, 0, 32'h7fffffff, 1, 0);
		add_row(OP_SUMNZ,  32'h00000003, 32'h00000003, 0, 0, 32'h00000000, 0, 1);
		add_row(OP_AND,    32'h0f0f0f0f, 32'hff00ff00, 0, 0, 32'h0f000f00, 0, 0);
		add_row(OP_MUXC,   32'h0000ffff, 32'h12345678, 1, 0, 32'h1234ffff, 1, 0);
		add_row(OP_SHL,    32'h00000001, 32'h80000001, 0, 0, 32'h00000002, 1, 0);
		add_row(OP_ROR,    32'h00000001, 32'h00000001, 0, 0, 32'h80000000, 1, 0);
		add_row(OP_SAR,    32'h0000001f, 32'h80000000, 0, 0, 32'hffffffff, 0, 0);
		add_row(OP_RCL,    32'h0000001f, 32'h00000001, 1, 0, 32'hffffffff, 0, 0);
		add_row(OP_REV,    32'h0000001f, 32'h00000001, 0, 0, 32'h00000001, 1, 0);
		add_row(OP_NEG,    32'h80000000, 32'h00000000, 0, 0, 32'h80000000, 1, 0);
		add_row(OP_ABS,    32'hfffffffb, 32'h00000000, 0, 0, 32'h00000005, 1, 0);
		add_row(OP_ABSNEG, 32'h00000005, 32'h00000000, 0, 0, 32'hfffffffb, 0, 0);
		add_row(OP_MIN,    32'h00000000, 32'h00000005, 0, 0, 32'h00000005, 0, 1);
		add_row(OP_MINS,   32'h00000001, 32'hffffffff, 0, 0, 32'h00000001, 1, 0);
		add_row(OP_MAXS,   32'h00000001, 32'hffffffff, 0, 0, 32'hffffffff, 1, 0);
	endtask

	task automatic add_random_rows();
		alu_op_e op;
		word_t   s;
		word_t   d;
		logic    c;
		logic    z;
		word_t   q;
		logic    qc;
		logic    qz;
		op = op.first();
		do
		begin
			for (int k = 0; k < RAND_PER_OP; k++)
			begin
				s = rand_bits(WORD_W);
				d = rand_bits(WORD_W);
				c = rand_bits(1) != '0;
				z = rand_bits(1) != '0;
				// Shift amounts 0, 1 and 31 before a random one
				if (op[OP_W-1 -: GRP_W] == GRP_SHIFT && k < 3)
					s[SHAMT_W-1:0] = (k == 0) ? 5'd0 : (k == 1) ? 5'd1 : 5'd31;
				acog_ref_model(op, s, d, c, z, q, qc, qz);
				add_row(op, s, d, c, z, q, qc, qz);
			end
			op = op.next();
		end
		while (op != op.first());
	endtask

	task automatic check_outputs();
		row_t r;
		int   t;
		if (valid_o)
		begin
			if (pending.size() == 0)
			begin
				$display("Unexpected valid_o at cycle %0d with nothing in flight", cycles);
				err_hs++;
			end
			else
			begin
				r = pending.pop_front();
				t = issued.pop_front();
				if (cycles - t != LATENCY)
				begin
					$display("Result of %s came %0d cycles after issue", r.op.name(), cycles - t);
					err_hs++;
				end
				if (q_o !== r.eq)
				begin
					$display("ERR q_o got %h expected %h (%s)", q_o, r.eq, r.op.name());
					err_val++;
				end
				if (flag_c_o !== r.ec)
				begin
					$display("ERR flag_c_o got %h expected %h (%s)", flag_c_o, r.ec, r.op.name());
					err_val++;
				end
				if (flag_z_o !== r.ez)
				begin
					$display("ERR flag_z_o got %h expected %h (%s)", flag_z_o, r.ez, r.op.name());
					err_val++;
				end
			end
		end
		else if (pending.size() > 0 && cycles - issued[0] > LATENCY)
		begin
			r = pending.pop_front();
			t = issued.pop_front();
			$display("No valid_o for %s issued at cycle %0d", r.op.name(), t);
			err_hs++;
		end
	endtask

	initial
	begin
		clk_in   = 1'b0;
		rst_i    = 1'b1;
		valid_i  = 1'b0;
		op_i     = OP_MOV;
		s_i      = '0;
		d_i      = '0;
		flag_c_i = 1'b0;
		flag_z_i = 1'b0;
		add_fixed_rows();
		add_random_rows();
		limit = tbl.size() + RESET_CYC + 20;
		repeat (RESET_CYC) @(negedge clk_in);
		rst_i = 1'b0;
		if (valid_o !== 1'b0 || q_o !== '0 || flag_c_o !== 1'b0 || flag_z_o !== 1'b0)
		begin
			$display("Outputs not cleared by reset: valid_o %h q_o %h", valid_o, q_o);
			err_hs++;
		end
		foreach (tbl[i])
		begin
			@(negedge clk_in);
			check_outputs();
			valid_i  = 1'b1;
			op_i     = tbl[i].op;
			s_i      = tbl[i].s;
			d_i      = tbl[i].d;
			flag_c_i = tbl[i].c;
			flag_z_i = tbl[i].z;
			pending.push_back(tbl[i]);
			issued.push_back(cycles);
		end
		@(negedge clk_in);
		check_outputs();
		valid_i = 1'b0;
		while (pending.size() > 0)
		begin
			@(negedge clk_in);
			check_outputs();
		end
		repeat (3) // Idle cycles to catch a stray valid_o
		begin
			@(negedge clk_in);
			check_outputs();
		end
		$display("Errors: %0d value, %0d handshake", err_val, err_hs);
		if (err_val + err_hs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin : watchdog
		@(posedge clk_in);
		while (cycles < limit)
			@(posedge clk_in);
		$display("Timeout: run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
design/acog_cfg_pkg.sv
design/acog_isa_pkg.sv
design/acog_operand_stage.sv
design/acog_arith.sv
design/acog_logic.sv
design/acog_shifter.sv
design/acog_result_stage.sv
design/acog_alu_top.sv
dv/acog_alu_tb.sv
